/* hdl/trigPkg.sv */
package trigPkg;

   // **************************************************
   // bus and datapath widths
   // **************************************************
   localparam int busW      = 32;
   localparam int addrW     = 9;
   localparam int sumW      = 8;
   localparam int frontW    = 16;
   localparam int backW     = 32;
   localparam int cntW      = 64;

   // backplane line whose rising edges are counted
   localparam int countLine = 7;

   // product id in upper half, variant and build in lower half
   localparam logic [31:0] sysRevision     = 32'hB100_0001;
   localparam logic [31:0] unusedBlockWord = 32'h0000_0123;

   // read block selector, 2 and 3 unused
   typedef enum logic [1:0] {
      ctrlBlock   = 2'd0,
      statusBlock = 2'd1
   } blockSelT;

   // **************************************************
   // word addresses
   // **************************************************
   typedef enum logic [addrW-1:0] {
      csrReg         = 9'h000,
      revisionWord   = 9'h001,
      blockReg       = 9'h003,
      coincWord      = 9'h005,
      clrReg         = 9'h009,
      numTrigLo      = 9'h00A,
      numTrigHi      = 9'h00B,
      runTicksLo     = 9'h00C,
      runTicksHi     = 9'h00D,
      frontRaw       = 9'h100,
      backRaw        = 9'h103,
      frontCoincMask = 9'h108,
      backCoincMask  = 9'h10B,
      frontMultMask  = 9'h110,
      backMultMask   = 9'h113,
      frontCoincPat  = 9'h118,
      backCoincPat   = 9'h11B,
      frontMultThr   = 9'h120,
      backMultThr    = 9'h123
   } regAddrT;

   // status words sharing an address with a control register
   localparam regAddrT frontMasked = frontCoincMask;
   localparam regAddrT backMasked  = backCoincMask;
   localparam regAddrT frontSum    = frontMultMask;
   localparam regAddrT backSum     = backMultMask;

endpackage

/* hdl/ctrlRegs.sv */
`timescale 1ns/1ns

module ctrlRegs
(
   input  logic                       proc_clk,
   input  logic                       rst,
   input  logic [3:0]                 wrStrb,
   input  logic [trigPkg::addrW-1:0]  addr,
   input  logic [trigPkg::busW-1:0]   wrData,
   output logic                       runEnable,
   output trigPkg::blockSelT          blockSel,
   output logic [trigPkg::frontW-1:0] frontCoincMask,
   output logic [trigPkg::frontW-1:0] frontCoincPat,
   output logic [trigPkg::frontW-1:0] frontMultMask,
   output logic [trigPkg::backW-1:0]  backCoincMask,
   output logic [trigPkg::backW-1:0]  backCoincPat,
   output logic [trigPkg::backW-1:0]  backMultMask,
   output logic [trigPkg::sumW-1:0]   frontMultThr,
   output logic [trigPkg::sumW-1:0]   backMultThr,
   output logic                       counterClr
);
   import trigPkg::*;

   regAddrT wrAddr;
   logic    anyStrb;

   // replace the strobed byte lanes of a stored word
   function automatic logic [busW-1:0] mergeBytes(input logic [busW-1:0] oldWord,
                                                  input logic [busW-1:0] newWord,
                                                  input logic [3:0]      strb);
      logic [busW-1:0] merged;
      merged = oldWord;
      for (int i = 0; i < 4; i++)
      begin
         if (strb[i])
            merged[8*i +: 8] = newWord[8*i +: 8];
      end
      return merged;
   endfunction

   assign wrAddr  = regAddrT'(addr);
   assign anyStrb = |wrStrb;

   // **************************************************
   // register bank
   // **************************************************
   always_ff @(posedge proc_clk)
   begin
      if (rst)
      begin
         runEnable      <= 1'b0;
         blockSel       <= ctrlBlock;
         frontCoincMask <= '0;
         frontCoincPat  <= '0;
         frontMultMask  <= '0;
         backCoincMask  <= '0;
         backCoincPat   <= '0;
         backMultMask   <= '0;
         frontMultThr   <= '0;
         backMultThr    <= '0;
         counterClr     <= 1'b0;
      end
      else
      begin
         // clear pulse lands one cycle after the write
         counterClr <= anyStrb && (wrAddr == trigPkg::clrReg);
         if (anyStrb)
         begin
            case (wrAddr)
               // only bit 0 of csr is implemented
               trigPkg::csrReg:
                  if (wrStrb[0])
                     runEnable <= wrData[0];
               trigPkg::blockReg:
                  if (wrStrb[0])
                     blockSel <= blockSelT'(wrData[1:0]);
               trigPkg::frontCoincMask:
                  frontCoincMask <= frontW'(mergeBytes(busW'(frontCoincMask), wrData, wrStrb));
               trigPkg::frontCoincPat:
                  frontCoincPat <= frontW'(mergeBytes(busW'(frontCoincPat), wrData, wrStrb));
               trigPkg::frontMultMask:
                  frontMultMask <= frontW'(mergeBytes(busW'(frontMultMask), wrData, wrStrb));
               trigPkg::backCoincMask:
                  backCoincMask <= backW'(mergeBytes(busW'(backCoincMask), wrData, wrStrb));
               trigPkg::backCoincPat:
                  backCoincPat <= backW'(mergeBytes(busW'(backCoincPat), wrData, wrStrb));
               trigPkg::backMultMask:
                  backMultMask <= backW'(mergeBytes(busW'(backMultMask), wrData, wrStrb));
               // thresholds only use the low byte
               trigPkg::frontMultThr:
                  frontMultThr <= sumW'(mergeBytes(busW'(frontMultThr), wrData, wrStrb));
               trigPkg::backMultThr:
                  backMultThr <= sumW'(mergeBytes(busW'(backMultThr), wrData, wrStrb));
               default:
               begin
               end
            endcase
         end
      end
   end

endmodule

/* hdl/chanGroup.sv */
`timescale 1ns/1ns

module chanGroup
#(
   parameter int groupW = 16
)
(
   input  logic                     proc_clk,
   input  logic                     rst,
   input  logic [groupW-1:0]        lines,
   input  logic [groupW-1:0]        coincMask,
   input  logic [groupW-1:0]        coincPat,
   input  logic [groupW-1:0]        multMask,
   input  logic [trigPkg::sumW-1:0] multThr,
   output logic [groupW-1:0]        masked,
   output logic                     coincOk,
   output logic [trigPkg::sumW-1:0] sum,
   output logic                     multOk
);
   import trigPkg::*;

   // four lines per partial sum
   localparam int numQuads = groupW / 4;

   logic [groupW-1:0] multLines;
   logic [2:0]        quadNext [numQuads];
   logic [2:0]        quadSum  [numQuads];
   logic [sumW-1:0]   totalNext;

   // coincidence path, no pipeline
   assign masked  = lines & coincMask;
   assign coincOk = (masked == coincPat);

   assign multLines = lines & multMask;

   // popcount of each quad
   always_comb
   begin
      for (int q = 0; q < numQuads; q++)
      begin
         quadNext[q] = '0;
         for (int b = 0; b < 4; b++)
            quadNext[q] = quadNext[q] + 3'(multLines[4*q + b]);
      end
   end

   // add up registered quads
   always_comb
   begin
      totalNext = '0;
      for (int q = 0; q < numQuads; q++)
         totalNext = totalNext + sumW'(quadSum[q]);
   end

   // **************************************************
   // stage 1 quads, stage 2 total
   // **************************************************
   always_ff @(posedge proc_clk)
   begin
      if (rst)
      begin
         for (int q = 0; q < numQuads; q++)
            quadSum[q] <= '0;
         sum <= '0;
      end
      else
      begin
         for (int q = 0; q < numQuads; q++)
            quadSum[q] <= quadNext[q];
         sum <= totalNext;
      end
   end

   // threshold check on the registered total
   assign multOk = (sum >= multThr);

endmodule

/* hdl/eventCounters.sv */
`timescale 1ns/1ns

module eventCounters
(
   input  logic                     proc_clk,
   input  logic                     rst,
   input  logic                     counterClr,
   input  logic                     trigLine,
   output logic [trigPkg::cntW-1:0] runTicks,
   output logic [trigPkg::cntW-1:0] numTrig
);
   import trigPkg::*;

   // [0] newest sample, [1] previous
   logic [1:0] trigHist;
   logic       trigRise;

   assign trigRise = trigHist[0] & ~trigHist[1];

   always_ff @(posedge proc_clk)
   begin
      if (rst)
      begin
         trigHist <= '0;
         runTicks <= '0;
         numTrig  <= '0;
      end
      else
      begin
         trigHist <= {trigHist[0], trigLine};
         // clear wins over counting
         if (counterClr)
         begin
            runTicks <= '0;
            numTrig  <= '0;
         end
         else
         begin
            runTicks <= runTicks + cntW'(1);
            if (trigRise)
               numTrig <= numTrig + cntW'(1);
         end
      end
   end

endmodule

/* hdl/readPort.sv */
`timescale 1ns/1ns

module readPort
(
   input  logic                       proc_clk,
   input  logic                       rst,
   input  logic                       rdEn,
   input  logic [trigPkg::addrW-1:0]  addr,
   input  trigPkg::blockSelT          blockSel,
   input  logic                       runEnable,
   input  logic [trigPkg::frontW-1:0] frontCoincMask,
   input  logic [trigPkg::frontW-1:0] frontCoincPat,
   input  logic [trigPkg::frontW-1:0] frontMultMask,
   input  logic [trigPkg::backW-1:0]  backCoincMask,
   input  logic [trigPkg::backW-1:0]  backCoincPat,
   input  logic [trigPkg::backW-1:0]  backMultMask,
   input  logic [trigPkg::sumW-1:0]   frontMultThr,
   input  logic [trigPkg::sumW-1:0]   backMultThr,
   input  logic [trigPkg::frontW-1:0] frontRaw,
   input  logic [trigPkg::backW-1:0]  backRaw,
   input  logic [trigPkg::frontW-1:0] frontMasked,
   input  logic [trigPkg::backW-1:0]  backMasked,
   input  logic                       frontCoincOk,
   input  logic                       backCoincOk,
   input  logic [trigPkg::sumW-1:0]   frontSum,
   input  logic [trigPkg::sumW-1:0]   backSum,
   input  logic                       frontMultOk,
   input  logic                       backMultOk,
   input  logic [trigPkg::cntW-1:0]   runTicks,
   input  logic [trigPkg::cntW-1:0]   numTrig,
   output logic [trigPkg::busW-1:0]   rdData
);
   import trigPkg::*;

   regAddrT         rdAddr;
   logic [busW-1:0] ctrlWord;
   logic [busW-1:0] statusWord;

   assign rdAddr = regAddrT'(addr);

   // **************************************************
   // control block readback
   // **************************************************
   always_comb
   begin
      ctrlWord = '0;
      case (rdAddr)
         trigPkg::csrReg:         ctrlWord = busW'(runEnable);
         trigPkg::blockReg:       ctrlWord = busW'(blockSel);
         trigPkg::frontCoincMask: ctrlWord = busW'(frontCoincMask);
         trigPkg::frontCoincPat:  ctrlWord = busW'(frontCoincPat);
         trigPkg::frontMultMask:  ctrlWord = busW'(frontMultMask);
         trigPkg::backCoincMask:  ctrlWord = busW'(backCoincMask);
         trigPkg::backCoincPat:   ctrlWord = busW'(backCoincPat);
         trigPkg::backMultMask:   ctrlWord = busW'(backMultMask);
         trigPkg::frontMultThr:   ctrlWord = busW'(frontMultThr);
         trigPkg::backMultThr:    ctrlWord = busW'(backMultThr);
         default:                 ctrlWord = '0;
      endcase
   end

   // **************************************************
   // status block
   // **************************************************
   always_comb
   begin
      statusWord = '0;
      case (rdAddr)
         trigPkg::csrReg:       statusWord[0] = runEnable;
         trigPkg::revisionWord: statusWord = sysRevision;
         // coincidence in the low nibble, multiplicity in the next byte
         trigPkg::coincWord:
         begin
            statusWord[0]  = frontCoincOk;
            statusWord[3]  = backCoincOk;
            statusWord[8]  = frontMultOk;
            statusWord[11] = backMultOk;
         end
         trigPkg::numTrigLo:    statusWord = numTrig[busW-1:0];
         trigPkg::numTrigHi:    statusWord = numTrig[cntW-1:busW];
         trigPkg::runTicksLo:   statusWord = runTicks[busW-1:0];
         trigPkg::runTicksHi:   statusWord = runTicks[cntW-1:busW];
         trigPkg::frontRaw:     statusWord = busW'(frontRaw);
         trigPkg::backRaw:      statusWord = busW'(backRaw);
         trigPkg::frontMasked:  statusWord = busW'(frontMasked);
         trigPkg::backMasked:   statusWord = busW'(backMasked);
         trigPkg::frontSum:     statusWord = busW'(frontSum);
         trigPkg::backSum:      statusWord = busW'(backSum);
         default:               statusWord = '0;
      endcase
   end

   // one cycle read latency, held between reads
   always_ff @(posedge proc_clk)
   begin
      if (rst)
         rdData <= '0;
      else if (rdEn)
      begin
         case (blockSel)
            ctrlBlock:   rdData <= ctrlWord;
            statusBlock: rdData <= statusWord;
            default:     rdData <= unusedBlockWord;
         endcase
      end
   end

endmodule

/* hdl/trigIoTop.sv */
`timescale 1ns/1ns

module trigIoTop
#(
   parameter int frontW = trigPkg::frontW,
   parameter int backW  = trigPkg::backW
)
(
   input  logic                      proc_clk,
   input  logic                      rst,
   input  logic [3:0]                wrStrb,
   input  logic [trigPkg::addrW-1:0] addr,
   input  logic [trigPkg::busW-1:0]  wrData,
   input  logic                      rdEn,
   output logic [trigPkg::busW-1:0]  rdData,
   input  logic [frontW-1:0]         frontIn,
   input  logic [backW-1:0]          backIn
);
   import trigPkg::*;

   // register bank outputs
   logic              runEnable;
   blockSelT          blockSel;
   logic [frontW-1:0] frontCoincMask;
   logic [frontW-1:0] frontCoincPat;
   logic [frontW-1:0] frontMultMask;
   logic [backW-1:0]  backCoincMask;
   logic [backW-1:0]  backCoincPat;
   logic [backW-1:0]  backMultMask;
   logic [sumW-1:0]   frontMultThr;
   logic [sumW-1:0]   backMultThr;
   logic              counterClr;

   // group results
   logic [frontW-1:0] frontMasked;
   logic              frontCoincOk;
   logic [sumW-1:0]   frontSum;
   logic              frontMultOk;
   logic [backW-1:0]  backMasked;
   logic              backCoincOk;
   logic [sumW-1:0]   backSum;
   logic              backMultOk;

   // counters
   logic [cntW-1:0]   runTicks;
   logic [cntW-1:0]   numTrig;

   ctrlRegs regs (
      .proc_clk, .rst, .wrStrb, .addr, .wrData,
      .runEnable, .blockSel,
      .frontCoincMask, .frontCoincPat, .frontMultMask,
      .backCoincMask, .backCoincPat, .backMultMask,
      .frontMultThr, .backMultThr, .counterClr
   );

   // front panel lines
   chanGroup #(.groupW(frontW)) frontGrp (
      .proc_clk, .rst, .lines(frontIn),
      .coincMask(frontCoincMask), .coincPat(frontCoincPat),
      .multMask(frontMultMask), .multThr(frontMultThr),
      .masked(frontMasked), .coincOk(frontCoincOk),
      .sum(frontSum), .multOk(frontMultOk)
   );

   // backplane lines
   chanGroup #(.groupW(backW)) backGrp (
      .proc_clk, .rst, .lines(backIn),
      .coincMask(backCoincMask), .coincPat(backCoincPat),
      .multMask(backMultMask), .multThr(backMultThr),
      .masked(backMasked), .coincOk(backCoincOk),
      .sum(backSum), .multOk(backMultOk)
   );

   eventCounters counters (
      .proc_clk, .rst, .counterClr,
      .trigLine(backIn[countLine]),
      .runTicks, .numTrig
   );

   readPort rdPort (
      .proc_clk, .rst, .rdEn, .addr, .blockSel, .runEnable,
      .frontCoincMask, .frontCoincPat, .frontMultMask,
      .backCoincMask, .backCoincPat, .backMultMask,
      .frontMultThr, .backMultThr,
      .frontRaw(frontIn), .backRaw(backIn),
      .frontMasked, .backMasked, .frontCoincOk, .backCoincOk,
      .frontSum, .backSum, .frontMultOk, .backMultOk,
      .runTicks, .numTrig, .rdData
   );

endmodule

/* tests/busTasks.svh */
`ifndef BUS_TASKS_SVH
`define BUS_TASKS_SVH

// one write access, strobe high for a single cycle
task automatic busWrite(input logic [addrW-1:0] wAddr,
                        input logic [busW-1:0]  wData,
                        input logic [3:0]       strb);
   @(posedge proc_clk);
   #1;
   addr   = wAddr;
   wrData = wData;
   wrStrb = strb;
   @(posedge proc_clk);
   #1;
   wrStrb = '0;
endtask

// one read access, data taken one cycle after the strobe
task automatic busRead(input logic [addrW-1:0] rAddr,
                       output logic [busW-1:0] rData);
   @(posedge proc_clk);
   #1;
   addr = rAddr;
   rdEn = 1'b1;
   @(posedge proc_clk);
   #1;
   rdEn  = 1'b0;
   rData = rdData;
endtask

// count and print a wrong value
task automatic reportErr(input string testName,
                         input logic [busW-1:0] expVal,
                         input logic [busW-1:0] actVal);
   valueErrs++;
   $display("ERR %s expected %h actual %h", testName, expVal, actVal);
endtask

task automatic checkEq(input string testName,
                       input logic [busW-1:0] expVal,
                       input logic [busW-1:0] actVal);
   assert (actVal == expVal)
   else
      reportErr(testName, expVal, actVal);
endtask

`endif

/* tests/trigIoTb.sv */
`timescale 1ns/1ns

module trigIoTb;
   import trigPkg::*;

   logic              proc_clk;
   logic              rst;
   logic [3:0]        wrStrb;
   logic [addrW-1:0]  addr;
   logic [busW-1:0]   wrData;
   logic              rdEn;
   logic [busW-1:0]   rdData;
   logic [frontW-1:0] frontIn;
   logic [backW-1:0]  backIn;

   integer seed;
   int     valueErrs;
   int     protoErrs;
   bit     timedOut;

   trigIoTop #(.frontW(frontW), .backW(backW)) DUT (
      .proc_clk, .rst, .wrStrb, .addr, .wrData, .rdEn, .rdData, .frontIn, .backIn
   );

   `include "busTasks.svh"

   initial
   begin
      proc_clk = 1'b0;
      forever #5 proc_clk = ~proc_clk;
   end

   // **************************************************
   // bus protocol checks
   // **************************************************
   // rdData only moves after a read strobe
   readHold: assert property (@(posedge proc_clk) disable iff (rst) !rdEn |=> $stable(rdData))
   else
   begin
      protoErrs++;
      $display("rdData changed in a cycle without a read strobe before it");
   end

   // reset clears the read register
   resetZero: assert property (@(posedge proc_clk) rst |=> rdData == '0)
   else
   begin
      protoErrs++;
      $display("rdData was not zero after a reset cycle");
   end

   // new line values 1 ns after the edge
   task automatic driveLines(input logic [frontW-1:0] f, input logic [backW-1:0] b);
      @(posedge proc_clk);
      #1;
      frontIn = f;
      backIn  = b;
   endtask

   // poll until the trigger count reads zero
   task automatic waitTrigCleared(output logic [busW-1:0] val);
      int tries;
      tries = 0;
      val   = '1;
      while (val != '0 && tries < 10)
      begin
         busRead(numTrigLo, val);
         tries++;
      end
      if (val != '0)
      begin
         timedOut = 1'b1;
         $display("timeout while waiting for the trigger count to clear");
      end
   endtask

   // **************************************************
   // control block readback
   // **************************************************
   task automatic checkCtrlRegs();
      logic [addrW-1:0] regAddr [8];
      logic [busW-1:0]  widthMask [8];
      logic [busW-1:0]  shadow [8];
      logic [busW-1:0]  laneMask;
      logic [busW-1:0]  newVal;
      logic [busW-1:0]  got;
      logic [3:0]       strb;
      regAddr   = '{frontCoincMask, frontCoincPat, frontMultMask, backCoincMask,
                    backCoincPat, backMultMask, frontMultThr, backMultThr};
      widthMask = '{32'h0000_FFFF, 32'h0000_FFFF, 32'h0000_FFFF, 32'hFFFF_FFFF,
                    32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_00FF, 32'h0000_00FF};
      for (int i = 0; i < 8; i++)
         shadow[i] = '0;
      // two rounds so partial lanes land on older data
      for (int r = 0; r < 2; r++)
      begin
         for (int i = 0; i < 8; i++)
         begin
            newVal = $random(seed);
            strb   = 4'($random(seed));
            if (strb == 4'h0)
               strb = 4'b0101;
            laneMask  = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
            shadow[i] = ((shadow[i] & ~laneMask) | (newVal & laneMask)) & widthMask[i];
            busWrite(regAddr[i], newVal, strb);
         end
      end
      for (int i = 0; i < 8; i++)
      begin
         busRead(regAddr[i], got);
         checkEq($sformatf("ctrl reg %h", regAddr[i]), shadow[i], got);
      end
      busRead(9'h050, got);
      checkEq("ctrl unmapped", '0, got);
      // block 2 has no contents
      busWrite(blockReg, 32'h2, 4'h1);
      busRead(csrReg, got);
      checkEq("unused block", unusedBlockWord, got);
      busWrite(blockReg, 32'h1, 4'h1);
   endtask

   task automatic checkStatusIdentity();
      logic [busW-1:0]   got;
      logic [frontW-1:0] lineF;
      logic [backW-1:0]  lineB;
      busRead(revisionWord, got);
      checkEq("revision", sysRevision, got);
      busWrite(csrReg, 32'h1, 4'h1);
      busRead(csrReg, got);
      checkEq("csr run on", 32'h1, got);
      busWrite(csrReg, 32'h0, 4'hF);
      busRead(csrReg, got);
      checkEq("csr run off", 32'h0, got);
      lineF = 16'($random(seed));
      lineB = $random(seed);
      driveLines(lineF, lineB);
      busRead(frontRaw, got);
      checkEq("front raw", 32'(lineF), got);
      busRead(backRaw, got);
      checkEq("back raw", lineB, got);
   endtask

   // **************************************************
   // coincidence and multiplicity
   // **************************************************
   task automatic checkCoincidence();
      logic [busW-1:0]   got;
      logic [frontW-1:0] lineF, maskF, patF;
      logic [backW-1:0]  lineB, maskB, patB;
      for (int i = 0; i < 4; i++)
      begin
         lineF = 16'($random(seed));
         maskF = 16'($random(seed));
         lineB = $random(seed);
         maskB = $random(seed);
         patF  = 16'($random(seed));
         patB  = $random(seed);
         // first pass matches both groups and the second only the front
         if (i < 2)
            patF = lineF & maskF;
         if (i == 0)
            patB = lineB & maskB;
         busWrite(frontCoincMask, 32'(maskF), 4'hF);
         busWrite(frontCoincPat, 32'(patF), 4'hF);
         busWrite(backCoincMask, maskB, 4'hF);
         busWrite(backCoincPat, patB, 4'hF);
         driveLines(lineF, lineB);
         busRead(frontMasked, got);
         checkEq("front masked", 32'(lineF & maskF), got);
         busRead(backMasked, got);
         checkEq("back masked", lineB & maskB, got);
         busRead(coincWord, got);
         checkEq("coinc front", 32'((lineF & maskF) == patF), 32'(got[0]));
         checkEq("coinc back", 32'((lineB & maskB) == patB), 32'(got[3]));
      end
   endtask

   task automatic checkMultiplicity();
      logic [busW-1:0]   got;
      logic [frontW-1:0] lineF, mmF;
      logic [backW-1:0]  lineB, mmB;
      int                cntF, cntB, thrF, thrB;
      for (int i = 0; i < 3; i++)
      begin
         lineF = 16'($random(seed));
         mmF   = 16'($random(seed));
         lineB = $random(seed);
         mmB   = $random(seed);
         busWrite(frontMultMask, 32'(mmF), 4'hF);
         busWrite(backMultMask, mmB, 4'hF);
         driveLines(lineF, lineB);
         // two pipeline stages plus margin
         repeat (3) @(posedge proc_clk);
         cntF = $countones(lineF & mmF);
         cntB = $countones(lineB & mmB);
         busRead(frontSum, got);
         checkEq("front sum", 32'(cntF), got);
         busRead(backSum, got);
         checkEq("back sum", 32'(cntB), got);
         // threshold below, at and above the count
         for (int off = -1; off <= 1; off++)
         begin
            thrF = (cntF + off < 0) ? 0 : cntF + off;
            thrB = (cntB + off < 0) ? 0 : cntB + off;
            busWrite(frontMultThr, 32'(thrF), 4'h1);
            busWrite(backMultThr, 32'(thrB), 4'h1);
            busRead(coincWord, got);
            checkEq("mult front thr", 32'(cntF >= thrF), 32'(got[8]));
            checkEq("mult back thr", 32'(cntB >= thrB), 32'(got[11]));
         end
      end
   endtask

   // **************************************************
   // counters
   // **************************************************
   task automatic checkTrigCount();
      logic [busW-1:0] got;
      logic [busW-1:0] rnd;
      int              nPulses, hiCycles, loCycles;
      @(posedge proc_clk);
      #1;
      backIn[countLine] = 1'b0;
      repeat (3) @(posedge proc_clk);
      busWrite(clrReg, 32'h1, 4'hF);
      rnd     = $random(seed);
      nPulses = 3 + int'(rnd[1:0]);
      for (int p = 0; p < nPulses; p++)
      begin
         rnd      = $random(seed);
         hiCycles = 3 + int'(rnd[1:0] % 3);
         loCycles = 3 + int'(rnd[3:2] % 3);
         @(posedge proc_clk);
         #1;
         backIn[countLine] = 1'b1;
         repeat (hiCycles) @(posedge proc_clk);
         #1;
         backIn[countLine] = 1'b0;
         repeat (loCycles) @(posedge proc_clk);
      end
      repeat (4) @(posedge proc_clk);
      busRead(numTrigLo, got);
      checkEq("trig count", 32'(nPulses), got);
      busRead(numTrigHi, got);
      checkEq("trig count hi", '0, got);
      busWrite(clrReg, 32'h1, 4'hF);
      waitTrigCleared(got);
      checkEq("trig after clear", '0, got);
   endtask

   task automatic checkTicks();
      logic [busW-1:0] t1, t2;
      busRead(runTicksLo, t1);
      busRead(runTicksLo, t2);
      assert (t2 > t1)
      else
         reportErr("ticks increase", t1 + 32'd1, t2);
      busWrite(clrReg, 32'h1, 4'hF);
      busRead(runTicksLo, t1);
      // read lands a few cycles after the clear
      assert (t1 < 32'd20)
      else
         reportErr("ticks after clear", 32'd19, t1);
   endtask

   // late reset while rdData holds a nonzero word
   task automatic resetAfterRead();
      logic [busW-1:0] got;
      busRead(revisionWord, got);
      checkEq("revision before reset", sysRevision, got);
      @(posedge proc_clk);
      #1;
      rst = 1'b1;
      repeat (3) @(posedge proc_clk);
      #1;
      rst = 1'b0;
      @(posedge proc_clk);
      #1;
   endtask

   task automatic runTests();
      checkCtrlRegs();
      checkStatusIdentity();
      checkCoincidence();
      checkMultiplicity();
      checkTrigCount();
      if (timedOut)
         return;
      checkTicks();
      resetAfterRead();
   endtask

   initial
   begin
      seed      = 32'hd62f_72a9;
      valueErrs = 0;
      protoErrs = 0;
      timedOut  = 1'b0;
      rst       = 1'b1;
      wrStrb    = '0;
      addr      = '0;
      wrData    = '0;
      rdEn      = 1'b0;
      frontIn   = '0;
      backIn    = '0;
      repeat (3) @(posedge proc_clk);
      #1;
      rst = 1'b0;
      runTests();
      $display("errors: value %0d, protocol %0d, timeout %0d", valueErrs, protoErrs, timedOut);
      if (valueErrs == 0 && protoErrs == 0 && !timedOut)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+tests
hdl/trigPkg.sv
hdl/ctrlRegs.sv
hdl/chanGroup.sv
hdl/eventCounters.sv
hdl/readPort.sv
hdl/trigIoTop.sv
tests/trigIoTb.sv

/* run.sh */
#!/bin/sh
# build and run the trigger board simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module trigIoTb -f filelist.f -o simTrig
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/simTrig)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

# pass only when the testbench printed its pass line
if echo "$out" | grep -qx "TEST PASSED"; then
   exit 0
fi
exit 1
